/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f bicubic_column.f --top-module bicubic_column_tb
	@out="$$(./obj_dir/Vbicubic_column_tb)"; echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

/* bicubic_column.f */
+incdir+tb
design/scaler_pkg.sv
design/cubic_pkg.sv
design/frac_divider.sv
design/frac_table_builder.sv
design/sram_arbiter.sv
design/column_fetcher.sv
design/cubic_engine.sv
design/bicubic_column.sv
tb/bicubic_column_tb.sv

/* design/bicubic_column.sv */
`timescale 1ns/1ps
`default_nettype none

module bicubic_column (
    input  wire                           CLK,
    input  wire                           RST,
    input  wire [scaler_pkg::ROW_W-1:0]   v0_i,
    input  wire [scaler_pkg::ROW_W-1:0]   h0_i,
    input  wire [scaler_pkg::SPAN_W-1:0]  sh_i,
    input  wire [scaler_pkg::SPAN_W-1:0]  th_i,
    output logic [scaler_pkg::ADDR_W-1:0] rom_addr_o,
    input  wire cubic_pkg::pixel_t        rom_data_i,
    output logic                          sram_cen_o,
    output logic                          sram_wen_o,
    output logic [scaler_pkg::ADDR_W-1:0] sram_addr_o,
    output cubic_pkg::pixel_t             sram_wdata_o,
    input  wire cubic_pkg::pixel_t        sram_rdata_i,
    output logic                          done_o
);
    import scaler_pkg::*;
    import cubic_pkg::*;

    logic              div_start, div_done, table_done;
    logic [SPAN_W-1:0] dividend;
    frac_t             div_quot, tb_wdata, frac;
    logic              tb_req, tb_grant, wb_req, wb_grant, fe_req, fe_grant;
    logic [ADDR_W-1:0] tb_addr, wb_addr, fe_addr;
    pixel_t            wb_wdata, p0, p1, p2, p3;
    logic              rdata_valid, sample_valid, credit_return, last_write, fetch_done;

    frac_divider u_div (
        .CLK(CLK), .RST(RST), .div_start_i(div_start), .dividend_i(dividend),
        .divisor_i(th_i - SPAN_W'(1)), .quotient_o(div_quot), .div_done_o(div_done)
    );

    frac_table_builder u_table (
        .CLK(CLK), .RST(RST), .th_i(th_i), .div_start_o(div_start), .dividend_o(dividend),
        .quotient_i(div_quot), .div_done_i(div_done), .req_o(tb_req), .addr_o(tb_addr),
        .wdata_o(tb_wdata), .grant_i(tb_grant), .table_done_o(table_done)
    );

    sram_arbiter u_arb (
        .CLK(CLK), .RST(RST),
        .tb_req_i(tb_req), .tb_addr_i(tb_addr), .tb_we_i(1'b1), .tb_wdata_i(tb_wdata),
        .tb_grant_o(tb_grant),
        .wb_req_i(wb_req), .wb_addr_i(wb_addr), .wb_we_i(1'b1), .wb_wdata_i(wb_wdata),
        .wb_grant_o(wb_grant),
        .fe_req_i(fe_req), .fe_addr_i(fe_addr), .fe_we_i(1'b0), .fe_wdata_i('0),
        .fe_grant_o(fe_grant),
        .sram_cen_o(sram_cen_o), .sram_wen_o(sram_wen_o), .sram_addr_o(sram_addr_o),
        .sram_wdata_o(sram_wdata_o), .rdata_valid_o(rdata_valid)
    );

    column_fetcher u_fetch (
        .CLK(CLK), .RST(RST), .table_done_i(table_done), .v0_i(v0_i), .h0_i(h0_i),
        .sh_i(sh_i), .th_i(th_i), .req_o(fe_req), .addr_o(fe_addr), .grant_i(fe_grant),
        .rdata_valid_i(rdata_valid), .sram_rdata_i(sram_rdata_i), .rom_addr_o(rom_addr_o),
        .rom_data_i(rom_data_i), .sample_valid_o(sample_valid), .p0_o(p0), .p1_o(p1),
        .p2_o(p2), .p3_o(p3), .frac_o(frac), .credit_return_i(credit_return),
        .fetch_done_o(fetch_done)
    );

    cubic_engine u_engine (
        .CLK(CLK), .RST(RST), .th_i(th_i), .sample_valid_i(sample_valid),
        .p0_i(p0), .p1_i(p1), .p2_i(p2), .p3_i(p3), .frac_i(frac),
        .req_o(wb_req), .addr_o(wb_addr), .wdata_o(wb_wdata), .grant_i(wb_grant),
        .credit_return_o(credit_return), .last_write_o(last_write)
    );

    // sticky until reset, one cycle after the last row is written
    always_ff @(posedge CLK) begin
        if (RST) begin
            done_o <= 1'b0;
        end else if (last_write && fetch_done) begin
            done_o <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* design/column_fetcher.sv */
`timescale 1ns/1ps
`default_nettype none

module column_fetcher (
    input  wire                           CLK,
    input  wire                           RST,
    input  wire                           table_done_i,
    input  wire [scaler_pkg::ROW_W-1:0]   v0_i,
    input  wire [scaler_pkg::ROW_W-1:0]   h0_i,
    input  wire [scaler_pkg::SPAN_W-1:0]  sh_i,
    input  wire [scaler_pkg::SPAN_W-1:0]  th_i,
    output logic                          req_o,
    output logic [scaler_pkg::ADDR_W-1:0] addr_o,
    input  wire                           grant_i,
    input  wire                           rdata_valid_i,
    input  wire cubic_pkg::frac_t         sram_rdata_i,
    output logic [scaler_pkg::ADDR_W-1:0] rom_addr_o,
    input  wire cubic_pkg::pixel_t        rom_data_i,
    output logic                          sample_valid_o,
    output cubic_pkg::pixel_t             p0_o,
    output cubic_pkg::pixel_t             p1_o,
    output cubic_pkg::pixel_t             p2_o,
    output cubic_pkg::pixel_t             p3_o,
    output cubic_pkg::frac_t              frac_o,
    input  wire                           credit_return_i,
    output logic                          fetch_done_o
);
    import scaler_pkg::*;
    import cubic_pkg::*;

    localparam int CRED_W = $clog2(CREDITS + 1);

    typedef enum logic [2:0] {
        ST_WAIT,
        ST_TREQ,
        ST_TDATA,
        ST_ROM,
        ST_SEND,
        ST_DONE
    } state_t;

    state_t            state_q;
    logic [ROW_W-1:0]  quot_q;
    logic [ROW_W-1:0]  rem_q;    // j*(SH-1) mod (TH-1)
    logic [ROW_W-1:0]  rem_sum;
    logic [ROW_W-1:0]  th_m1;
    logic [ROW_W-1:0]  rom_row;
    logic [SPAN_W-1:0] row_q;    // target row j
    logic [CRED_W-1:0] credit_q;
    logic [2:0]        phase_q;
    pixel_t            gather_q [4];
    frac_t             frac_q;

    assign th_m1   = ROW_W'(th_i) - 1'b1;
    assign rem_sum = rem_q + ROW_W'(sh_i) - 1'b1;
    // rows quot-1 .. quot+2, phase 4 only collects the last pixel
    assign rom_row = v0_i + quot_q + ROW_W'(phase_q[1:0]) - 1'b1;

    always_ff @(posedge CLK) begin
        if (RST) begin
            state_q <= ST_WAIT;
            quot_q  <= '0;
            rem_q   <= '0;
            row_q   <= '0;
            phase_q <= '0;
        end else begin
            case (state_q)
                ST_WAIT: begin
                    // no credit, no table read
                    if (table_done_i && credit_q != '0) state_q <= ST_TREQ;
                end
                ST_TREQ: begin
                    if (grant_i) state_q <= ST_TDATA;
                end
                ST_TDATA: begin
                    if (rdata_valid_i) begin
                        state_q <= ST_ROM;
                        phase_q <= '0;
                    end
                end
                ST_ROM: begin
                    phase_q <= phase_q + 1'b1;
                    if (phase_q == 3'd4) state_q <= ST_SEND;
                end
                ST_SEND: begin
                    if (rem_sum >= th_m1) begin  // wrap, next source row
                        rem_q  <= rem_sum - th_m1;
                        quot_q <= quot_q + 1'b1;
                    end else begin
                        rem_q <= rem_sum;
                    end
                    row_q   <= row_q + 1'b1;
                    state_q <= (row_q == th_i - 1'b1) ? ST_DONE : ST_WAIT;
                end
                default: state_q <= ST_DONE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (state_q == ST_TDATA && rdata_valid_i) frac_q <= sram_rdata_i;
        if (state_q == ST_ROM && phase_q != 3'd0) begin
            gather_q[0] <= gather_q[1];
            gather_q[1] <= gather_q[2];
            gather_q[2] <= gather_q[3];
            gather_q[3] <= rom_data_i;  // one cycle behind its address
        end
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            credit_q <= CRED_W'(CREDITS);
        end else if (sample_valid_o && !credit_return_i) begin
            credit_q <= credit_q - 1'b1;
        end else if (credit_return_i && !sample_valid_o) begin
            credit_q <= credit_q + 1'b1;
        end
    end

    assign req_o          = (state_q == ST_TREQ);
    assign addr_o         = {ROW_W'(TABLE_ROW), rem_q};
    assign rom_addr_o     = ADDR_W'(rom_row) * ADDR_W'(IMG_W) + ADDR_W'(h0_i);
    assign sample_valid_o = (state_q == ST_SEND);
    assign p0_o           = gather_q[0];
    assign p1_o           = gather_q[1];
    assign p2_o           = gather_q[2];
    assign p3_o           = gather_q[3];
    assign frac_o         = frac_q;
    assign fetch_done_o   = (state_q == ST_DONE);

    // credits returned by the engine never exceed what was handed out
    assert property (@(posedge CLK) disable iff (RST)
        credit_q <= CRED_W'(CREDITS) && (sample_valid_o -> credit_q != '0));

endmodule

`default_nettype wire

/* design/cubic_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module cubic_engine (
    input  wire                           CLK,
    input  wire                           RST,
    input  wire [scaler_pkg::SPAN_W-1:0]  th_i,
    input  wire                           sample_valid_i,
    input  wire cubic_pkg::pixel_t        p0_i,
    input  wire cubic_pkg::pixel_t        p1_i,
    input  wire cubic_pkg::pixel_t        p2_i,
    input  wire cubic_pkg::pixel_t        p3_i,
    input  wire cubic_pkg::frac_t         frac_i,
    output logic                          req_o,
    output logic [scaler_pkg::ADDR_W-1:0] addr_o,
    output cubic_pkg::pixel_t             wdata_o,
    input  wire                           grant_i,
    output logic                          credit_return_o,
    output logic                          last_write_o
);
    import scaler_pkg::*;
    import cubic_pkg::*;

    typedef logic signed [COEF_W-1:0] coef_t;
    typedef logic signed [ACC_W-1:0]  acc_t;

    coef_t            x0, x1, x2, x3;  // zero-extended pixels
    coef_t            a1_q, b1_q, c1_q, d1_q, c2_q, d2_q, d3_q;
    frac_t            f1_q, f2_q, f3_q;
    acc_t             h2_q, h3_q, s, rnd;
    logic             v1_q, v2_q, v3_q;
    logic [ROW_W-1:0] in_row_q, row1_q, row2_q, row3_q;
    pixel_t           res;
    pixel_t           buf_pix [2];
    logic [ROW_W-1:0] buf_row [2];
    logic             wr_ptr_q, rd_ptr_q;
    logic [1:0]       count_q;

    assign x0 = coef_t'(p0_i);
    assign x1 = coef_t'(p1_i);
    assign x2 = coef_t'(p2_i);
    assign x3 = coef_t'(p3_i);

    // last stage: finish horner, round by 2^24, shift, clamp
    assign s   = h3_q * acc_t'(f3_q) + (acc_t'(d3_q) <<< 24);
    assign rnd = (s + (acc_t'(1) <<< (ROUND_SHIFT - 1))) >>> ROUND_SHIFT;
    always_comb begin
        if (rnd < 0)                          res = '0;
        else if (rnd > acc_t'(2**PIX_W - 1))  res = '1;
        else                                  res = rnd[PIX_W-1:0];
    end

    always_ff @(posedge CLK) begin
        a1_q <= x3 - x0 + 3 * (x1 - x2);  // coefficients
        b1_q <= 2 * x0 - 5 * x1 + 4 * x2 - x3;
        c1_q <= x2 - x0;
        d1_q <= 2 * x1;
        f1_q <= frac_i;
        row1_q <= in_row_q;
        h2_q <= acc_t'(a1_q) * acc_t'(f1_q) + (acc_t'(b1_q) <<< 8);  // a*f + 256b
        c2_q <= c1_q;
        d2_q <= d1_q;
        f2_q <= f1_q;
        row2_q <= row1_q;
        h3_q <= h2_q * acc_t'(f2_q) + (acc_t'(c2_q) <<< 16);
        d3_q <= d2_q;
        f3_q <= f2_q;
        row3_q <= row2_q;
        if (v3_q) begin
            buf_pix[wr_ptr_q] <= res;
            buf_row[wr_ptr_q] <= row3_q;
        end
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            {v1_q, v2_q, v3_q} <= 3'b000;
            in_row_q <= '0;
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            count_q  <= '0;
        end else begin
            {v1_q, v2_q, v3_q} <= {sample_valid_i, v1_q, v2_q};
            if (sample_valid_i) in_row_q <= in_row_q + 1'b1;
            if (v3_q) wr_ptr_q <= ~wr_ptr_q;
            if (grant_i) rd_ptr_q <= ~rd_ptr_q;
            count_q <= count_q + {1'b0, v3_q} - {1'b0, grant_i};
        end
    end

    assign req_o           = (count_q != '0);
    assign addr_o          = {buf_row[rd_ptr_q], ROW_W'(RESULT_COL)};
    assign wdata_o         = buf_pix[rd_ptr_q];
    assign credit_return_o = grant_i;  // slot freed
    assign last_write_o    = grant_i && buf_row[rd_ptr_q] == ROW_W'(th_i) - 1'b1;

    // the fetcher's credits keep the two-entry buffer from overflowing
    assert property (@(posedge CLK) disable iff (RST) v3_q |-> count_q < 2'd2 || grant_i);

endmodule

`default_nettype wire

/* design/cubic_pkg.sv */
`default_nettype none

package cubic_pkg;

    localparam int PIX_W  = 8;
    localparam int FRAC_W = 8;   // Q0.8

    typedef logic [PIX_W-1:0]  pixel_t;
    typedef logic [FRAC_W-1:0] frac_t;

    // kernel widths
    localparam int COEF_W      = 12;  // a and b reach +-1530
    localparam int ACC_W       = 36;  // signed horner accumulator
    localparam int ROUND_SHIFT = 25;  // 2^24 scale plus the factor 2 in d

endpackage

`default_nettype wire

/* design/frac_divider.sv */
`timescale 1ns/1ps
`default_nettype none

module frac_divider (
    input  wire                          CLK,
    input  wire                          RST,
    input  wire                          div_start_i,
    input  wire [scaler_pkg::SPAN_W-1:0] dividend_i,
    input  wire [scaler_pkg::SPAN_W-1:0] divisor_i,
    output cubic_pkg::frac_t             quotient_o,
    output logic                         div_done_o
);
    import scaler_pkg::*;
    import cubic_pkg::*;

    localparam int CNT_W = $clog2(DIV_CYCLES);

    logic [SPAN_W:0]  rem_q;    // partial remainder, stays below divisor
    logic [SPAN_W:0]  rem_src;
    logic [SPAN_W:0]  rem_shl;
    logic             fits;
    logic [CNT_W-1:0] cnt_q;
    logic             busy_q;
    frac_t            quot_q;

    // first bit is resolved in the start cycle itself
    assign rem_src = div_start_i ? {1'b0, dividend_i} : rem_q;
    assign rem_shl = {rem_src[SPAN_W-1:0], 1'b0};
    assign fits    = rem_shl >= {1'b0, divisor_i};

    always_ff @(posedge CLK) begin
        if (RST) begin
            busy_q     <= 1'b0;
            cnt_q      <= '0;
            div_done_o <= 1'b0;
        end else begin
            div_done_o <= 1'b0;
            if (div_start_i) begin
                busy_q <= 1'b1;
                cnt_q  <= CNT_W'(DIV_CYCLES - 1);
            end else if (busy_q) begin
                cnt_q <= cnt_q - 1'b1;
                if (cnt_q == CNT_W'(1)) begin  // last bit this cycle
                    busy_q     <= 1'b0;
                    div_done_o <= 1'b1;
                end
            end
        end
    end

    // restoring step, quotient frozen once busy drops
    always_ff @(posedge CLK) begin
        if (div_start_i || busy_q) begin
            rem_q  <= fits ? rem_shl - {1'b0, divisor_i} : rem_shl;
            quot_q <= {quot_q[FRAC_W-2:0], fits};
        end
    end

    assign quotient_o = quot_q;

endmodule

`default_nettype wire

/* design/frac_table_builder.sv */
`timescale 1ns/1ps
`default_nettype none

module frac_table_builder (
    input  wire                           CLK,
    input  wire                           RST,
    input  wire [scaler_pkg::SPAN_W-1:0]  th_i,
    output logic                          div_start_o,
    output logic [scaler_pkg::SPAN_W-1:0] dividend_o,
    input  wire cubic_pkg::frac_t         quotient_i,
    input  wire                           div_done_i,
    output logic                          req_o,
    output logic [scaler_pkg::ADDR_W-1:0] addr_o,
    output cubic_pkg::frac_t              wdata_o,
    input  wire                           grant_i,
    output logic                          table_done_o
);
    import scaler_pkg::*;

    typedef enum logic [1:0] {
        ST_START,
        ST_WAIT,
        ST_WRITE,
        ST_DONE
    } state_t;

    state_t            state_q;
    logic [SPAN_W-1:0] k_q;     // table entry being built
    logic              last_k;

    assign last_k = (k_q == th_i - SPAN_W'(2));

    always_ff @(posedge CLK) begin
        if (RST) begin
            state_q <= ST_START;
            k_q     <= '0;
        end else begin
            case (state_q)
                ST_START: state_q <= ST_WAIT;
                ST_WAIT: begin
                    if (div_done_i) state_q <= ST_WRITE;
                end
                ST_WRITE: begin
                    if (grant_i && last_k) begin
                        state_q <= ST_DONE;
                    end else if (grant_i) begin
                        k_q     <= k_q + 1'b1;
                        state_q <= ST_START;
                    end
                end
                default: state_q <= ST_DONE;  // held until reset
            endcase
        end
    end

    assign div_start_o  = (state_q == ST_START);
    assign dividend_o   = k_q;  // divisor th-1 comes from the top
    assign req_o        = (state_q == ST_WRITE);
    assign addr_o       = {ROW_W'(TABLE_ROW), ROW_W'(k_q)};
    assign wdata_o      = quotient_i;  // divider holds it until next start
    assign table_done_o = (state_q == ST_DONE);

    // the divider answers only while an entry waits for it
    assert property (@(posedge CLK) disable iff (RST) div_done_i |-> state_q == ST_WAIT);

endmodule

`default_nettype wire

/* design/scaler_pkg.sv */
`default_nettype none

package scaler_pkg;

    // source image and memory map
    localparam int IMG_W      = 100;
    localparam int ROW_W      = 7;   // one row or column field
    localparam int ADDR_W     = 14;
    localparam int TABLE_ROW  = 101; // sram row holding the fraction table
    localparam int RESULT_COL = 1;

    // run control
    localparam int CREDITS    = 2;   // result slots inside the engine
    localparam int DIV_CYCLES = 8;   // one quotient bit per cycle
    localparam int SPAN_W     = 6;   // sh/th inputs

    // peers on the shared sram port, highest priority first
    typedef enum logic [1:0] {
        REQ_TABLE = 2'd0,
        REQ_WB    = 2'd1,
        REQ_FETCH = 2'd2
    } sram_req_t;

endpackage

`default_nettype wire

/* design/sram_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_arbiter (
    input  wire                           CLK,
    input  wire                           RST,
    input  wire                           tb_req_i,
    input  wire [scaler_pkg::ADDR_W-1:0]  tb_addr_i,
    input  wire                           tb_we_i,
    input  wire cubic_pkg::pixel_t        tb_wdata_i,
    output logic                          tb_grant_o,
    input  wire                           wb_req_i,
    input  wire [scaler_pkg::ADDR_W-1:0]  wb_addr_i,
    input  wire                           wb_we_i,
    input  wire cubic_pkg::pixel_t        wb_wdata_i,
    output logic                          wb_grant_o,
    input  wire                           fe_req_i,
    input  wire [scaler_pkg::ADDR_W-1:0]  fe_addr_i,
    input  wire                           fe_we_i,
    input  wire cubic_pkg::pixel_t        fe_wdata_i,
    output logic                          fe_grant_o,
    output logic                          sram_cen_o,
    output logic                          sram_wen_o,
    output logic [scaler_pkg::ADDR_W-1:0] sram_addr_o,
    output cubic_pkg::pixel_t             sram_wdata_o,
    output logic                          rdata_valid_o
);
    import scaler_pkg::*;

    sram_req_t sel;
    logic      any_req;
    logic      sel_we;

    always_comb begin
        sel = REQ_FETCH;
        if (tb_req_i) begin
            sel = REQ_TABLE;
        end else if (wb_req_i) begin
            sel = REQ_WB;
        end
    end

    assign any_req    = tb_req_i | wb_req_i | fe_req_i;
    assign tb_grant_o = tb_req_i;  // top priority never waits
    assign wb_grant_o = (sel == REQ_WB);
    assign fe_grant_o = fe_req_i && (sel == REQ_FETCH);

    always_comb begin
        case (sel)
            REQ_TABLE: begin
                sram_addr_o  = tb_addr_i;
                sel_we       = tb_we_i;
                sram_wdata_o = tb_wdata_i;
            end
            REQ_WB: begin
                sram_addr_o  = wb_addr_i;
                sel_we       = wb_we_i;
                sram_wdata_o = wb_wdata_i;
            end
            default: begin
                sram_addr_o  = fe_addr_i;
                sel_we       = fe_we_i;
                sram_wdata_o = fe_wdata_i;
            end
        endcase
    end

    assign sram_cen_o = !any_req;             // active low
    assign sram_wen_o = !(any_req && sel_we); // low means write

    // read data shows up one cycle after a granted read
    always_ff @(posedge CLK) begin
        if (RST) rdata_valid_o <= 1'b0;
        else     rdata_valid_o <= any_req && !sel_we;
    end

    // a waiting peer keeps its request and address until granted
    assert property (@(posedge CLK) disable iff (RST)
        wb_req_i && !wb_grant_o |=> wb_req_i && $stable(wb_addr_i));
    assert property (@(posedge CLK) disable iff (RST)
        fe_req_i && !fe_grant_o |=> fe_req_i && $stable(fe_addr_i));

endmodule

`default_nettype wire

/* tb/bicubic_model.svh */
`ifndef BICUBIC_MODEL_SVH
`define BICUBIC_MODEL_SVH

// fraction table entry k, Q0.8
function automatic integer table_entry(input int k, input int th);
    return (k * 256) / (th - 1);
endfunction

// source position of target row j as quotient and remainder over th-1
function automatic int source_quot(input int j, input int sh, input int th);
    return (j * (sh - 1)) / (th - 1);
endfunction

function automatic int source_rem(input int j, input int sh, input int th);
    return (j * (sh - 1)) % (th - 1);
endfunction

// catmull-rom with the 2^24 scale folded into d, rounded and clamped
function automatic integer cubic_kernel(input int p0, input int p1, input int p2,
                                       input int p3, input int f);
    longint a, b, c, d, s, r;
    a = -p0 + 3 * p1 - 3 * p2 + p3;
    b = 2 * p0 - 5 * p1 + 4 * p2 - p3;
    c = p2 - p0;
    d = 2 * p1;
    s = a * f * f * f + b * f * f * 256 + c * f * 65536 + d * 16777216;
    r = (s + 16777216) >>> 25;
    if (r < 0) begin
        return 0;
    end
    if (r > 255) begin
        return 255;
    end
    return integer'(r);
endfunction

// galois lfsr, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
        return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
endfunction

`endif

/* tb/bicubic_column_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module bicubic_column_tb;
    import scaler_pkg::*;

    localparam int TIMEOUT_CYCLES = 5000;
    localparam int QUIET_CYCLES   = 40;  // watch window after done_o

    logic              CLK = 1'b0;
    logic              RST;
    logic [ROW_W-1:0]  v0_i;
    logic [ROW_W-1:0]  h0_i;
    logic [SPAN_W-1:0] sh_i;
    logic [SPAN_W-1:0] th_i;
    logic [ADDR_W-1:0] rom_addr_o;
    logic [7:0]        rom_data_i = '0;
    logic              sram_cen_o;
    logic              sram_wen_o;
    logic [ADDR_W-1:0] sram_addr_o;
    logic [7:0]        sram_wdata_o;
    logic [7:0]        sram_rdata_i = '0;
    logic              done_o;

    logic [7:0]  rom_mem  [0:IMG_W*IMG_W-1];
    logic [7:0]  sram_mem [0:2**ADDR_W-1];
    int          table_cnt [0:127];  // writes per table column
    int          res_cnt   [0:127];  // writes per result row
    int          stray_cnt;
    int          late_cnt;
    logic [31:0] lfsr_state;
    int          err_count;
    int          tests_run;
    int          tests_failed;

    `include "bicubic_model.svh"

    bicubic_column dut (
        .CLK(CLK), .RST(RST), .v0_i(v0_i), .h0_i(h0_i), .sh_i(sh_i), .th_i(th_i),
        .rom_addr_o(rom_addr_o), .rom_data_i(rom_data_i),
        .sram_cen_o(sram_cen_o), .sram_wen_o(sram_wen_o), .sram_addr_o(sram_addr_o),
        .sram_wdata_o(sram_wdata_o), .sram_rdata_i(sram_rdata_i), .done_o(done_o)
    );

    always #20 CLK = ~CLK;

    // image rom is always enabled
    always @(posedge CLK) begin
        rom_data_i <= rom_mem[rom_addr_o];
    end

    // result sram plus a write log that reset clears
    always @(posedge CLK) begin
        if (!sram_cen_o && !sram_wen_o) begin
            sram_mem[sram_addr_o] <= sram_wdata_o;
        end else if (!sram_cen_o) begin
            sram_rdata_i <= sram_mem[sram_addr_o];
        end
        if (RST) begin
            for (int i = 0; i < 128; i++) begin
                table_cnt[i] <= 0;
                res_cnt[i]   <= 0;
            end
            stray_cnt <= 0;
            late_cnt  <= 0;
        end else if (!sram_cen_o && !sram_wen_o) begin
            if (sram_addr_o[13:7] == ROW_W'(TABLE_ROW)) begin
                table_cnt[sram_addr_o[6:0]] <= table_cnt[sram_addr_o[6:0]] + 1;
            end else if (sram_addr_o[6:0] == ROW_W'(RESULT_COL)) begin
                res_cnt[sram_addr_o[13:7]] <= res_cnt[sram_addr_o[13:7]] + 1;
            end else begin
                stray_cnt <= stray_cnt + 1;
            end
            if (done_o) late_cnt <= late_cnt + 1;
        end
    end

    function automatic logic [7:0] random_byte();
        logic [7:0] b;
        b = '0;
        for (int n = 0; n < 8; n++) begin
            b = {b[6:0], lfsr_state[0]};  // one step per bit
            lfsr_state = lfsr_next(lfsr_state);
        end
        return b;
    endfunction

    function automatic integer rom_pixel(input int row, input int col);
        return integer'(rom_mem[ADDR_W'(row * IMG_W + col)]);
    endfunction

    function automatic integer sram_byte(input int row, input int col);
        return integer'(sram_mem[ADDR_W'(row * 128 + col)]);
    endfunction

    task automatic check_value(input string what, input integer got, input integer exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s = %0d, expected %0d", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic fill_random_image();
        for (int a = 0; a < IMG_W * IMG_W; a++) begin
            rom_mem[ADDR_W'(a)] = random_byte();
        end
    endtask

    task automatic fill_constant_image(input logic [7:0] value);
        for (int a = 0; a < IMG_W * IMG_W; a++) begin
            rom_mem[ADDR_W'(a)] = value;
        end
    endtask

    // reset with a new configuration and wait for done_o
    task automatic run_config(input int v0, input int h0, input int sh, input int th,
                              output bit done_seen);
        int cycles;
        @(posedge CLK);
        RST  <= 1'b1;
        v0_i <= ROW_W'(v0);
        h0_i <= ROW_W'(h0);
        sh_i <= SPAN_W'(sh);
        th_i <= SPAN_W'(th);
        repeat (4) @(posedge CLK);
        RST <= 1'b0;
        @(negedge CLK);
        check_value("done_o after reset", integer'(done_o), 0);
        cycles = 0;
        while (!done_o && cycles < TIMEOUT_CYCLES) begin
            @(negedge CLK);
            cycles++;
        end
        done_seen = done_o;
        if (!done_o) begin
            $display("timeout: done_o still low after %0d cycles (sh=%0d th=%0d)",
                     cycles, sh, th);
            err_count++;
        end
    endtask

    task automatic check_table(input int th);
        for (int k = 0; k < th - 1; k++) begin
            check_value($sformatf("table writes k=%0d", k), table_cnt[k], 1);
            check_value($sformatf("sram table[%0d]", k), sram_byte(TABLE_ROW, k),
                        table_entry(k, th));
        end
        for (int k = th - 1; k < 128; k++) begin
            check_value($sformatf("table writes k=%0d", k), table_cnt[k], 0);
        end
    endtask

    task automatic check_results(input int v0, input int h0, input int sh, input int th);
        int q;
        int f;
        integer exp;
        for (int j = 0; j < th; j++) begin
            q   = source_quot(j, sh, th);
            f   = table_entry(source_rem(j, sh, th), th);
            exp = cubic_kernel(rom_pixel(v0 + q - 1, h0), rom_pixel(v0 + q, h0),
                               rom_pixel(v0 + q + 1, h0), rom_pixel(v0 + q + 2, h0), f);
            check_value($sformatf("sram result row %0d", j), sram_byte(j, RESULT_COL), exp);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (err_count == errs_before) begin
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: %0d check(s) failed", name, err_count - errs_before);
        end
    endtask

    task automatic test_table_phase();
        int errs_before;
        bit ok;
        errs_before = err_count;
        fill_random_image();
        run_config(10, 37, 15, 28, ok);
        if (ok) check_table(28);
        report_test("table phase", errs_before);
    endtask

    task automatic test_constant_image();
        int errs_before;
        bit ok;
        errs_before = err_count;
        fill_constant_image(8'd137);
        run_config(20, 50, 15, 28, ok);
        if (ok) begin
            for (int j = 0; j < 28; j++) begin
                check_value($sformatf("sram result row %0d", j), sram_byte(j, RESULT_COL), 137);
            end
        end
        report_test("constant image", errs_before);
    endtask

    task automatic test_random_image();
        int errs_before;
        bit ok;
        errs_before = err_count;
        fill_random_image();
        run_config(30, 63, 15, 28, ok);
        if (ok) check_results(30, 63, 15, 28);
        report_test("random image", errs_before);
    endtask

    task automatic test_completion();
        int errs_before;
        int total;
        bit ok;
        errs_before = err_count;
        run_config(5, 99, 15, 28, ok);
        if (ok) begin
            total = 0;
            for (int r = 0; r < 128; r++) begin
                total += res_cnt[r];
            end
            for (int j = 0; j < 28; j++) begin
                check_value($sformatf("result writes row %0d", j), res_cnt[j], 1);
            end
            check_value("result writes total", total, 28);
            check_value("writes outside table and result column", stray_cnt, 0);
            repeat (QUIET_CYCLES) @(negedge CLK);
            check_value("writes after done_o", late_cnt, 0);
            check_value("done_o held", integer'(done_o), 1);
        end
        report_test("completion", errs_before);
    endtask

    task automatic test_second_config();
        int errs_before;
        bit ok;
        errs_before = err_count;
        fill_random_image();
        run_config(40, 12, 9, 17, ok);
        if (ok) begin
            check_table(17);
            check_results(40, 12, 9, 17);
        end
        report_test("second configuration", errs_before);
    endtask

    initial begin
        RST          = 1'b1;
        v0_i         = '0;
        h0_i         = '0;
        sh_i         = '0;
        th_i         = '0;
        lfsr_state   = 32'h6431;
        err_count    = 0;
        tests_run    = 0;
        tests_failed = 0;

        test_table_phase();
        test_constant_image();
        test_random_image();
        test_completion();
        test_second_config();

        $display("%0d tests run, %0d with errors, %0d failed checks",
                 tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
